/* common/vm_pkg.sv */
package vm_pkg;

  ////////////////////
  // widths and sizes

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [7:0]  var_idx_t;
  typedef logic [7:0]  prog_addr_t;
  typedef logic [3:0]  sp_t;

  localparam int PROG_DEPTH  = 256;
  localparam int STACK_DEPTH = 16;
  localparam int VAR_COUNT   = 256;

  ////////////////////
  // work page geometry

  localparam int PAGE_W      = 320;
  localparam int PAGE_H      = 200;
  localparam int PAGE_COUNT  = 4;
  localparam int PAGE_PIXELS = PAGE_W * PAGE_H;

  typedef logic [8:0]  page_x_t;
  typedef logic [7:0]  page_y_t;
  typedef logic [17:0] pix_addr_t;
  typedef logic [3:0]  color_t;

  ////////////////////
  // opcodes

  localparam byte_t OP_MOV_CONST = 8'h00;
  localparam byte_t OP_MOV       = 8'h01;
  localparam byte_t OP_ADD       = 8'h02;
  localparam byte_t OP_ADD_CONST = 8'h03;
  localparam byte_t OP_CALL      = 8'h04;
  localparam byte_t OP_RET       = 8'h05;
  localparam byte_t OP_JMP       = 8'h07;
  localparam byte_t OP_DJNZ      = 8'h09;
  localparam byte_t OP_FILL_PAGE = 8'h0E;
  localparam byte_t OP_SUB       = 8'h13;
  localparam byte_t OP_AND       = 8'h14;
  localparam byte_t OP_OR        = 8'h15;
  localparam byte_t OP_SHL       = 8'h16;
  localparam byte_t OP_SHR       = 8'h17;

  // operation applied to the variable file in the exec step
  typedef enum logic [3:0] {
    ALU_LOAD,
    ALU_COPY,
    ALU_ADD,
    ALU_ADD_K,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SHL,
    ALU_SHR,
    ALU_DEC
  } alu_op_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_OPERAND,
    S_EXEC,
    S_FILL
  } seq_state_t;

  ////////////////////
  // bundles

  typedef struct packed {
    logic     valid;
    alu_op_t  op;
    var_idx_t dst;
    var_idx_t src;
    word_t    operand;
  } alu_req_t;

  typedef struct packed {
    logic     valid;
    var_idx_t idx;
    word_t    value;
  } var_write_t;

  typedef struct packed {
    logic      valid;
    pix_addr_t addr;
    color_t    color;
  } pix_write_t;

endpackage

/* design/program_rom.sv */
`timescale 1ns/1ps

module program_rom
  import vm_pkg::*;
(
  input  logic       clk,
  input  logic       load_en,
  input  prog_addr_t load_addr,
  input  byte_t      load_data,
  input  prog_addr_t pc,
  output byte_t      rom_data
);

  byte_t mem [PROG_DEPTH];

  // load port
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // async read, sequencer decodes in the same cycle
  assign rom_data = mem[pc];

endmodule

/* design/call_stack.sv */
`timescale 1ns/1ps

module call_stack
  import vm_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  logic       pop,
  input  prog_addr_t ret_addr,
  output prog_addr_t top_addr
);

  prog_addr_t stack_mem [STACK_DEPTH];
  sp_t        sp;

  // sp points at the next free slot
  assign top_addr = stack_mem[sp - 1'b1];

  always_ff @(posedge clk) begin
    if (!reset) begin
      sp <= '0;
    end else if (push) begin
      sp <= sp + 1'b1;
    end else if (pop) begin
      sp <= sp - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_mem[sp] <= ret_addr;
    end
  end

endmodule

/* design/var_file_alu.sv */
`timescale 1ns/1ps

module var_file_alu
  import vm_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  alu_req_t   alu_req,
  output var_write_t var_write,
  output logic       dec_zero
);

  word_t vars [VAR_COUNT];
  word_t dst_val;
  word_t src_val;
  word_t dec_val;
  word_t result;

  assign dst_val = vars[alu_req.dst];
  assign src_val = vars[alu_req.src];
  assign dec_val = dst_val - 16'd1;

  // djnz falls through when this goes high
  assign dec_zero = (dec_val == '0);

  always_comb begin
    case (alu_req.op)
      ALU_LOAD:  result = alu_req.operand;
      ALU_COPY:  result = src_val;
      ALU_ADD:   result = dst_val + src_val;
      ALU_ADD_K: result = dst_val + alu_req.operand;
      ALU_SUB:   result = dst_val - src_val;
      ALU_AND:   result = dst_val & src_val;
      ALU_OR:    result = dst_val | src_val;
      // amounts of 16 and up clear the word
      ALU_SHL:   result = dst_val << alu_req.operand;
      ALU_SHR:   result = dst_val >> alu_req.operand;
      ALU_DEC:   result = dec_val;
      default:   result = dst_val;
    endcase
  end

  // trace of the write that lands at the next edge
  assign var_write.valid = alu_req.valid;
  assign var_write.idx   = alu_req.dst;
  assign var_write.value = result;

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < VAR_COUNT; i++) begin
        vars[i] <= '0;
      end
    end else if (alu_req.valid) begin
      vars[alu_req.dst] <= result;
    end
  end

endmodule

/* design/raster_counter.sv */
`timescale 1ns/1ps

module raster_counter
  import vm_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    sweep_start,
  output page_x_t x,
  output page_y_t y,
  output logic    sweep_last,
  output logic    busy
);

  logic at_row_end;
  logic at_page_end;

  assign at_row_end  = (x == page_x_t'(PAGE_W - 1));
  assign at_page_end = (y == page_y_t'(PAGE_H - 1));

  // bottom right pixel of the page
  assign sweep_last = busy && at_row_end && at_page_end;

  always_ff @(posedge clk) begin
    if (!reset) begin
      x    <= '0;
      y    <= '0;
      busy <= 1'b0;
    end else if (sweep_start) begin
      x    <= '0;
      y    <= '0;
      busy <= 1'b1;
    end else if (busy) begin
      if (at_row_end) begin
        x <= '0;
        if (at_page_end) begin
          y    <= '0;
          busy <= 1'b0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

/* design/vm_sequencer.sv */
`timescale 1ns/1ps

module vm_sequencer
  import vm_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  byte_t      rom_data,
  output prog_addr_t pc,
  output alu_req_t   alu_req,
  input  logic       dec_zero,
  output logic       push,
  output logic       pop,
  output prog_addr_t ret_addr,
  input  prog_addr_t top_addr,
  output logic       sweep_start,
  input  logic       sweep_last,
  input  page_x_t    x,
  input  page_y_t    y,
  output pix_write_t pix_write
);

  seq_state_t state;
  byte_t      opcode;
  logic [1:0] byte_cnt;
  var_idx_t   dst;
  var_idx_t   src;
  word_t      operand;
  logic       last_operand;

  // operand bytes that follow each opcode
  function automatic logic [1:0] operand_len(input byte_t op);
    case (op)
      OP_MOV_CONST, OP_SHL, OP_SHR, OP_DJNZ:
        return 2'd3;
      OP_MOV, OP_ADD, OP_ADD_CONST, OP_SUB, OP_AND, OP_OR,
      OP_JMP, OP_CALL, OP_FILL_PAGE:
        return 2'd2;
      default:
        return 2'd0;
    endcase
  endfunction

  assign last_operand = (byte_cnt == operand_len(opcode) - 2'd1);

  // counter starts on the colour byte so the first pixel lands in S_FILL
  assign sweep_start = run && (state == S_OPERAND) && last_operand &&
                       (opcode == OP_FILL_PAGE);

  // return address is the byte after the call operands
  assign ret_addr = pc;

  ////////////////////
  // control

  always_ff @(posedge clk) begin
    if (!reset) begin
      state    <= S_IDLE;
      opcode   <= '0;
      byte_cnt <= '0;
      pc       <= '0;
    end else if (!run) begin
      state <= S_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          state <= S_FETCH;
        end
        S_FETCH: begin
          opcode   <= rom_data;
          pc       <= pc + 1'b1;
          byte_cnt <= '0;
          // unknown opcodes stay here, one cycle each
          if (rom_data == OP_RET) begin
            state <= S_EXEC;
          end else if (operand_len(rom_data) != 2'd0) begin
            state <= S_OPERAND;
          end
        end
        S_OPERAND: begin
          pc       <= pc + 1'b1;
          byte_cnt <= byte_cnt + 1'b1;
          if (last_operand) begin
            state <= (opcode == OP_FILL_PAGE) ? S_FILL : S_EXEC;
          end
        end
        S_EXEC: begin
          state <= S_FETCH;
          case (opcode)
            OP_JMP, OP_CALL: pc <= operand[7:0];
            OP_DJNZ: begin
              if (!dec_zero) begin
                pc <= operand[7:0];
              end
            end
            OP_RET:  pc <= top_addr;
            default: ;
          endcase
        end
        S_FILL: begin
          if (sweep_last) begin
            state <= S_FETCH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // operand capture, big endian 16-bit values shift in
  always_ff @(posedge clk) begin
    if (state == S_OPERAND) begin
      operand <= {operand[7:0], rom_data};
      if (byte_cnt == 2'd0) begin
        dst <= rom_data;
      end
      if (byte_cnt == 2'd1) begin
        src <= rom_data;
      end
    end
  end

  ////////////////////
  // exec step requests

  always_comb begin
    alu_req         = '0;
    alu_req.dst     = dst;
    alu_req.src     = src;
    alu_req.operand = operand;
    push            = 1'b0;
    pop             = 1'b0;
    if (state == S_EXEC) begin
      case (opcode)
        OP_MOV_CONST: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_LOAD;
        end
        OP_MOV: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_COPY;
        end
        OP_ADD: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_ADD;
        end
        OP_ADD_CONST: begin
          // constant is a single unsigned byte
          alu_req.valid   = 1'b1;
          alu_req.op      = ALU_ADD_K;
          alu_req.operand = {8'h00, operand[7:0]};
        end
        OP_SUB: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_SUB;
        end
        OP_AND: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_AND;
        end
        OP_OR: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_OR;
        end
        OP_SHL: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_SHL;
        end
        OP_SHR: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_SHR;
        end
        OP_DJNZ: begin
          alu_req.valid = 1'b1;
          alu_req.op    = ALU_DEC;
        end
        OP_CALL: push = 1'b1;
        OP_RET:  pop  = 1'b1;
        default: ;
      endcase
    end
  end

  // page number sits in dst, colour in the low operand byte
  always_comb begin
    pix_write.valid = (state == S_FILL);
    pix_write.addr  = pix_addr_t'(dst[1:0]) * pix_addr_t'(PAGE_PIXELS) +
                      pix_addr_t'(y) * pix_addr_t'(PAGE_W) + pix_addr_t'(x);
    pix_write.color = operand[3:0];
  end

endmodule

/* design/vm_cpu.sv */
`timescale 1ns/1ps

module vm_cpu
  import vm_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  logic       load_en,
  input  prog_addr_t load_addr,
  input  byte_t      load_data,
  output var_write_t var_write,
  output pix_write_t pix_write,
  output prog_addr_t pc
);

  byte_t      rom_data;
  alu_req_t   alu_req;
  logic       dec_zero;
  logic       push;
  logic       pop;
  prog_addr_t ret_addr;
  prog_addr_t top_addr;
  logic       sweep_start;
  logic       sweep_last;
  page_x_t    x;
  page_y_t    y;

  // bytecode store, loaded while the core is idle
  program_rom u_rom (
    .clk      (clk),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .pc       (pc),
    .rom_data (rom_data)
  );

  vm_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .rom_data   (rom_data),
    .pc         (pc),
    .alu_req    (alu_req),
    .dec_zero   (dec_zero),
    .push       (push),
    .pop        (pop),
    .ret_addr   (ret_addr),
    .top_addr   (top_addr),
    .sweep_start(sweep_start),
    .sweep_last (sweep_last),
    .x          (x),
    .y          (y),
    .pix_write  (pix_write)
  );

  var_file_alu u_vars (
    .clk      (clk),
    .reset    (reset),
    .alu_req  (alu_req),
    .var_write(var_write),
    .dec_zero (dec_zero)
  );

  call_stack u_stack (
    .clk     (clk),
    .reset   (reset),
    .push    (push),
    .pop     (pop),
    .ret_addr(ret_addr),
    .top_addr(top_addr)
  );

  // busy is not needed here, the sequencer tracks the fill by state
  raster_counter u_raster (
    .clk        (clk),
    .reset      (reset),
    .sweep_start(sweep_start),
    .x          (x),
    .y          (y),
    .sweep_last (sweep_last),
    .busy       ()
  );

endmodule

/* tb/vm_cpu_properties.sv */
`timescale 1ns/1ps

module vm_cpu_properties
  import vm_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       run,
  input seq_state_t state,
  input alu_req_t   alu_req,
  input pix_write_t pix_write,
  input page_x_t    x,
  input page_y_t    y,
  input logic       push,
  input prog_addr_t ret_addr,
  input prog_addr_t top_addr
);

  int fail_count = 0;

  // dropping run parks the core, no variable write after that
  no_var_write_after_stop: assert property (@(posedge clk) disable iff (!reset)
    !run |=> (state == S_IDLE) && !alu_req.valid)
    else begin
      $error("sequencer not idle or variable write issued after run went low");
      fail_count++;
    end

  // sweep start and fill state line up on the first pixel
  fill_starts_at_origin: assert property (@(posedge clk) disable iff (!reset)
    $rose(pix_write.valid) |-> (x == '0) && (y == '0))
    else begin
      $error("page fill does not start at the top left pixel");
      fail_count++;
    end

  // a call leaves its return address on top of the stack
  push_sets_stack_top: assert property (@(posedge clk) disable iff (!reset)
    push |=> top_addr == $past(ret_addr))
    else begin
      $error("stack top differs from the pushed return address");
      fail_count++;
    end

endmodule

/* tb/tb_vm_cpu.sv */
`timescale 1ns/1ps

module tb_vm_cpu
  import vm_pkg::*;
();

  // fill test dominates, the rest is a few hundred cycles
  localparam int TEST_CYCLES = PAGE_PIXELS + 6000;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic       clk;
  logic       reset;
  logic       run;
  logic       load_en;
  prog_addr_t load_addr;
  byte_t      load_data;
  var_write_t var_write;
  pix_write_t pix_write;
  prog_addr_t pc;

  byte_t       prog[$];
  var_write_t  got_vars[$];
  logic [31:0] rng_state;
  int          cycles;
  logic        pix_allowed;
  int          pix_count;
  pix_addr_t   pix_base;
  color_t      pix_color;

  vm_cpu UUT (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .var_write(var_write),
    .pix_write(pix_write),
    .pc       (pc)
  );

  bind vm_sequencer vm_cpu_properties u_props (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .state    (state),
    .alu_req  (alu_req),
    .pix_write(pix_write),
    .x        (x),
    .y        (y),
    .push     (push),
    .ret_addr (ret_addr),
    .top_addr (top_addr)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // compare tasks

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_idx(string name, var_idx_t expected, var_idx_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "index mismatch");
    end
  endtask

  task automatic check_pix(string name, pix_addr_t exp_addr, color_t exp_color,
                           pix_addr_t got_addr, color_t got_color);
    if (got_addr !== exp_addr || got_color !== exp_color) begin
      $display("[ERROR] %0t ns %s expected addr %h color %h actual addr %h color %h",
               $time, name, exp_addr, exp_color, got_addr, got_color);
      $display("TEST FAIL");
      $fatal(1, "pixel mismatch");
    end
  endtask

  ////////////////////
  // output monitors

  // mid cycle, outputs are settled here
  always @(negedge clk) begin
    if (var_write.valid) begin
      got_vars.push_back(var_write);
    end
    if (pix_write.valid) begin
      if (!pix_allowed || pix_count >= PAGE_PIXELS) begin
        $display("pixel write at %0t ns outside the expected page fill", $time);
        $display("TEST FAIL");
        $fatal(1, "stray pixel write");
      end else begin
        check_pix("pix_write", pix_base + pix_addr_t'(pix_count), pix_color,
                  pix_write.addr, pix_write.color);
        pix_count = pix_count + 1;
      end
    end
  end

  ////////////////////
  // program building and control

  function automatic word_t rand_word();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  // bytes per instruction, opcode included
  function automatic int instr_len(byte_t op);
    case (op)
      OP_MOV_CONST, OP_SHL, OP_SHR, OP_DJNZ:
        return 4;
      OP_MOV, OP_ADD, OP_ADD_CONST, OP_SUB, OP_AND, OP_OR,
      OP_JMP, OP_CALL, OP_FILL_PAGE:
        return 3;
      default:
        return 1;
    endcase
  endfunction

  task automatic put_instr(byte_t op, byte_t b0, byte_t b1, byte_t b2);
    byte_t args[3];
    args = '{b0, b1, b2};
    prog.push_back(op);
    for (int i = 0; i < instr_len(op) - 1; i++) begin
      prog.push_back(args[i]);
    end
  endtask

  // jump to itself, parks the core
  task automatic put_halt();
    byte_t here;
    here = byte_t'(prog.size());
    put_instr(OP_JMP, 8'h00, here, 8'h00);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = prog_addr_t'(i);
      load_data = prog[i];
    end
    @(negedge clk);
    load_en = 1'b0;
    prog.delete();
  endtask

  task automatic start_program();
    @(negedge clk);
    run = 1'b1;
  endtask

  task automatic stop_program();
    @(negedge clk);
    run = 1'b0;
    repeat (2) @(negedge clk);
    if (got_vars.size() != 0) begin
      $display("unexpected variable write to index %h after the last expected one",
               got_vars[0].idx);
      $display("TEST FAIL");
      $fatal(1, "extra variable write");
    end
  endtask

  task automatic expect_var(var_idx_t idx, word_t value);
    var_write_t got;
    while (got_vars.size() == 0) begin
      @(negedge clk);
    end
    got = got_vars.pop_front();
    check_idx("var_write.idx", idx, got.idx);
    check_word("var_write.value", value, got.value);
  endtask

  ////////////////////
  // tests

  task automatic test_move();
    word_t k;
    k = rand_word();
    put_instr(OP_MOV_CONST, 8'd10, k[15:8], k[7:0]);
    put_instr(OP_MOV, 8'd11, 8'd10, 8'h00);
    put_halt();
    load_program();
    start_program();
    expect_var(8'd10, k);
    expect_var(8'd11, k);
    stop_program();
  endtask

  task automatic test_alu();
    word_t a;
    word_t b;
    word_t c;
    word_t m;
    word_t r;
    word_t shl_amt;
    word_t shr_amt;
    byte_t k;
    a = rand_word();
    b = rand_word();
    c = rand_word();
    r = rand_word();
    k = r[7:0];
    shl_amt = {12'h000, r[11:8]};
    // up to 31, so some right shifts clear the word
    shr_amt = {11'h000, r[15:11]};
    put_instr(OP_MOV_CONST, 8'd20, a[15:8], a[7:0]);
    put_instr(OP_MOV_CONST, 8'd21, b[15:8], b[7:0]);
    put_instr(OP_MOV_CONST, 8'd22, c[15:8], c[7:0]);
    put_instr(OP_ADD, 8'd20, 8'd21, 8'h00);
    put_instr(OP_SUB, 8'd20, 8'd22, 8'h00);
    put_instr(OP_AND, 8'd20, 8'd21, 8'h00);
    put_instr(OP_OR, 8'd20, 8'd22, 8'h00);
    put_instr(OP_ADD_CONST, 8'd20, k, 8'h00);
    put_instr(OP_SHL, 8'd20, shl_amt[15:8], shl_amt[7:0]);
    put_instr(OP_SHR, 8'd20, shr_amt[15:8], shr_amt[7:0]);
    put_halt();
    load_program();
    start_program();
    expect_var(8'd20, a);
    expect_var(8'd21, b);
    expect_var(8'd22, c);
    m = a + b;
    expect_var(8'd20, m);
    m = m - c;
    expect_var(8'd20, m);
    m = m & b;
    expect_var(8'd20, m);
    m = m | c;
    expect_var(8'd20, m);
    m = m + {8'h00, k};
    expect_var(8'd20, m);
    m = m << shl_amt;
    expect_var(8'd20, m);
    m = m >> shr_amt;
    expect_var(8'd20, m);
    stop_program();
  endtask

  task automatic test_djnz();
    word_t marker;
    byte_t loop_at;
    marker = rand_word();
    put_instr(OP_MOV_CONST, 8'd40, 8'h00, 8'd5);
    loop_at = byte_t'(prog.size());
    put_instr(OP_DJNZ, 8'd40, 8'h00, loop_at);
    put_instr(OP_MOV_CONST, 8'd41, marker[15:8], marker[7:0]);
    put_halt();
    load_program();
    start_program();
    expect_var(8'd40, 16'd5);
    for (int n = 4; n >= 0; n--) begin
      expect_var(8'd40, word_t'(n));
    end
    expect_var(8'd41, marker);
    stop_program();
  endtask

  task automatic test_call();
    word_t after_call;
    word_t in_sub;
    after_call = rand_word();
    in_sub = rand_word();
    // call 3 bytes, movConst 4, halt 3, so the subroutine sits at 10
    put_instr(OP_CALL, 8'h00, 8'd10, 8'h00);
    put_instr(OP_MOV_CONST, 8'd50, after_call[15:8], after_call[7:0]);
    put_halt();
    put_instr(OP_MOV_CONST, 8'd51, in_sub[15:8], in_sub[7:0]);
    put_instr(OP_RET, 8'h00, 8'h00, 8'h00);
    load_program();
    start_program();
    expect_var(8'd51, in_sub);
    expect_var(8'd50, after_call);
    stop_program();
  endtask

  task automatic test_fill();
    word_t marker;
    marker = rand_word();
    put_instr(OP_FILL_PAGE, 8'd2, 8'd9, 8'h00);
    put_instr(OP_MOV_CONST, 8'd60, marker[15:8], marker[7:0]);
    put_halt();
    load_program();
    pix_base    = pix_addr_t'(2 * PAGE_PIXELS);
    pix_color   = 4'd9;
    pix_count   = 0;
    pix_allowed = 1'b1;
    start_program();
    // marker only comes once the sweep is over
    expect_var(8'd60, marker);
    if (pix_count != PAGE_PIXELS) begin
      $display("page fill made %0d pixel writes instead of %0d", pix_count, PAGE_PIXELS);
      $display("TEST FAIL");
      $fatal(1, "pixel count");
    end
    stop_program();
    pix_allowed = 1'b0;
  endtask

  ////////////////////
  // main sequence

  initial begin
    clk         = 1'b0;
    reset       = 1'b0;
    run         = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    rng_state   = 32'd48040;
    cycles      = 0;
    pix_allowed = 1'b0;
    pix_count   = 0;
    pix_base    = '0;
    pix_color   = '0;
    repeat (8) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    if (var_write.valid || pix_write.valid || pc != '0) begin
      $display("outputs not in their reset state after reset release");
      $display("TEST FAIL");
      $fatal(1, "reset state");
    end
    test_move();
    test_alu();
    test_djnz();
    test_call();
    test_fill();
    if (UUT.u_seq.u_props.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("%0d assertion failures during the run", UUT.u_seq.u_props.fail_count);
      $display("TEST FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

/* flist.f */
common/vm_pkg.sv
design/program_rom.sv
design/call_stack.sv
design/var_file_alu.sv
design/raster_counter.sv
design/vm_sequencer.sv
design/vm_cpu.sv
tb/vm_cpu_properties.sv
tb/tb_vm_cpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_vm_cpu -f flist.f -o sim_vm
	-./obj_dir/sim_vm > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
